/* dns_pkg.sv */
// *************************************************************************
// DNS response analyzer shared definitions
// stream and field widths, message layout byte counts,
// record type and class codes, parse section codes,
// and the union that reads a label-start byte in two ways
// *************************************************************************

package dns_pkg;

    // stream and field widths
    localparam int BYTE_W = 8;
    localparam int U16_W  = 16;
    localparam int TTL_W  = 32;
    localparam int ADDR_W = 32;

    // fixed part lengths in bytes
    localparam int HDR_BYTES  = 12;
    // qtype + qclass
    localparam int QFIX_BYTES = 4;
    // type, class, ttl, rdlength
    localparam int AFIX_BYTES = 10;

    // expected answer for an IPv4 lookup
    localparam logic [U16_W-1:0] A_RDLEN  = 16'd4;
    localparam logic [U16_W-1:0] TYPE_A   = 16'd1;
    localparam logic [U16_W-1:0] CLASS_IN = 16'd1;

    // top two bits of a label-start byte
    localparam logic [1:0] TAG_PTR   = 2'b11;
    localparam logic [1:0] TAG_LABEL = 2'b00;

    // parse sections, in stream order
    localparam int SEC_W = 3;
    localparam logic [SEC_W-1:0] SEC_HDR   = 3'd0;
    localparam logic [SEC_W-1:0] SEC_QNAME = 3'd1;
    localparam logic [SEC_W-1:0] SEC_QFIX  = 3'd2;
    localparam logic [SEC_W-1:0] SEC_ANAME = 3'd3;
    localparam logic [SEC_W-1:0] SEC_AFIX  = 3'd4;
    localparam logic [SEC_W-1:0] SEC_RDATA = 3'd5;
    // authority, additional, extra answers
    localparam logic [SEC_W-1:0] SEC_TAIL  = 3'd6;

    // byte offset inside a counted section
    localparam int OFF_W = 4;

    // label-start byte
    // label view holds the length of the label that follows
    // pointer view holds offset bits 13..8, the low byte comes next
    typedef union packed {
        struct packed {
            logic [1:0] tag;
            logic [5:0] len;
        } label;
        struct packed {
            logic [1:0] tag;
            logic [5:0] off_hi;
        } ptr;
    } dns_label_u;

endpackage

/* dns_parse_ctrl.sv */
// *************************************************************************
// DNS parse controller
// section FSM with per-section byte offset,
// end-of-frame verdict strobes
// *************************************************************************

`timescale 1ns/100ps

module dns_parse_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic                       in_last,
    input  logic                       name_done,
    input  logic                       ans_ok,
    output logic [dns_pkg::SEC_W-1:0]  sec,
    output logic [dns_pkg::OFF_W-1:0]  off,
    output logic                       dns_valid,
    output logic                       dns_error
);

    logic [dns_pkg::SEC_W-1:0] sec_nxt;
    logic [dns_pkg::OFF_W-1:0] off_nxt;

    // next section and offset if the current byte is accepted
    always_comb begin
        sec_nxt = sec;
        off_nxt = off + 1'b1;
        case (sec)
            dns_pkg::SEC_HDR: begin
                if (int'(off) == dns_pkg::HDR_BYTES - 1) begin
                    sec_nxt = dns_pkg::SEC_QNAME;
                    off_nxt = '0;
                end
            end
            dns_pkg::SEC_QNAME: begin
                // names are not counted, walker decides the end
                off_nxt = '0;
                if (name_done) begin
                    sec_nxt = dns_pkg::SEC_QFIX;
                end
            end
            dns_pkg::SEC_QFIX: begin
                if (int'(off) == dns_pkg::QFIX_BYTES - 1) begin
                    sec_nxt = dns_pkg::SEC_ANAME;
                    off_nxt = '0;
                end
            end
            dns_pkg::SEC_ANAME: begin
                off_nxt = '0;
                if (name_done) begin
                    sec_nxt = dns_pkg::SEC_AFIX;
                end
            end
            dns_pkg::SEC_AFIX: begin
                if (int'(off) == dns_pkg::AFIX_BYTES - 1) begin
                    sec_nxt = dns_pkg::SEC_RDATA;
                    off_nxt = '0;
                end
            end
            dns_pkg::SEC_RDATA: begin
                // only the 4 address bytes of an A record are walked
                if (int'(off) == int'(dns_pkg::A_RDLEN) - 1) begin
                    sec_nxt = dns_pkg::SEC_TAIL;
                    off_nxt = '0;
                end
            end
            default: begin
                // tail soaks up the rest of the frame
                sec_nxt = dns_pkg::SEC_TAIL;
                off_nxt = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sec       <= dns_pkg::SEC_HDR;
            off       <= '0;
            dns_valid <= 1'b0;
            dns_error <= 1'b0;
        end else begin
            // verdict strobes last one cycle
            dns_valid <= 1'b0;
            dns_error <= 1'b0;
            if (in_valid) begin
                if (in_last) begin
                    sec <= dns_pkg::SEC_HDR;
                    off <= '0;
                    // last address byte may itself be the final byte
                    if (sec_nxt == dns_pkg::SEC_TAIL && ans_ok) begin
                        dns_valid <= 1'b1;
                    end else begin
                        dns_error <= 1'b1;
                    end
                end else begin
                    sec <= sec_nxt;
                    off <= off_nxt;
                end
            end
        end
    end

    // one verdict per frame, never both
    a_verdict_onehot: assert property (@(posedge clk) disable iff (rst)
        !(dns_valid && dns_error));

    // names hold offset at zero, so counted sections bound it
    a_off_range: assert property (@(posedge clk) disable iff (rst)
        int'(off) < dns_pkg::HDR_BYTES);

endmodule

/* dns_name_walker.sv */
// *************************************************************************
// DNS name walker
// label skip counter and compression pointer tracking,
// flags the final byte of the question and answer names
// *************************************************************************

`timescale 1ns/100ps

module dns_name_walker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dns_pkg::BYTE_W-1:0] in_data,
    input  logic                       in_valid,
    input  logic [dns_pkg::SEC_W-1:0]  sec,
    output logic                       name_done
);

    dns_pkg::dns_label_u lbl;
    logic [5:0]          skip_cnt;
    logic                ptr_pend;
    logic                active;
    logic                at_start;
    logic                is_ptr;
    logic                is_label;

    assign lbl    = dns_pkg::dns_label_u'(in_data);
    assign active = (sec == dns_pkg::SEC_QNAME) || (sec == dns_pkg::SEC_ANAME);

    // current byte opens a label or a pointer
    assign at_start = (skip_cnt == '0) && !ptr_pend;
    assign is_ptr   = lbl.ptr.tag == dns_pkg::TAG_PTR;
    assign is_label = (lbl.label.tag == dns_pkg::TAG_LABEL) && (lbl.label.len != '0);

    // zero length byte or the low byte of a pointer closes the name
    // reserved tags 01 and 10 are taken as a name end too
    always_comb begin
        name_done = 1'b0;
        if (in_valid && active) begin
            if (ptr_pend) begin
                name_done = 1'b1;
            end else if (at_start && !is_ptr && !is_label) begin
                name_done = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !active) begin
            skip_cnt <= '0;
            ptr_pend <= 1'b0;
        end else if (in_valid) begin
            if (ptr_pend) begin
                ptr_pend <= 1'b0;
            end else if (skip_cnt != '0) begin
                // inside label text
                skip_cnt <= skip_cnt - 1'b1;
            end else if (is_ptr) begin
                ptr_pend <= 1'b1;
            end else if (is_label) begin
                skip_cnt <= lbl.label.len;
            end
        end
    end

    // end of name only on a real byte
    a_done_qual: assert property (@(posedge clk) disable iff (rst)
        name_done |-> in_valid);

endmodule

/* dns_hdr_capture.sv */
// *************************************************************************
// DNS header capture
// id, qdcount and ancount registers, flags word split
// *************************************************************************

`timescale 1ns/100ps

module dns_hdr_capture (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dns_pkg::BYTE_W-1:0] in_data,
    input  logic                       in_valid,
    input  logic [dns_pkg::SEC_W-1:0]  sec,
    input  logic [dns_pkg::OFF_W-1:0]  off,
    output logic [dns_pkg::U16_W-1:0]  hdr_id,
    output logic [dns_pkg::U16_W-1:0]  hdr_qdcount,
    output logic [dns_pkg::U16_W-1:0]  hdr_ancount,
    output logic                       hdr_qr,
    output logic                       hdr_aa,
    output logic                       hdr_rd,
    output logic [3:0]                 hdr_opcode,
    output logic [3:0]                 hdr_rcode
);

    localparam int LO = dns_pkg::U16_W - dns_pkg::BYTE_W;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_id      <= '0;
            hdr_qdcount <= '0;
            hdr_ancount <= '0;
            hdr_qr      <= 1'b0;
            hdr_aa      <= 1'b0;
            hdr_rd      <= 1'b0;
            hdr_opcode  <= '0;
            hdr_rcode   <= '0;
        end else if (in_valid && sec == dns_pkg::SEC_HDR) begin
            // network order, high byte arrives first
            case (int'(off))
                0, 1: hdr_id <= {hdr_id[LO-1:0], in_data};
                2: begin
                    // qr | opcode | aa | tc | rd
                    hdr_qr     <= in_data[7];
                    hdr_opcode <= in_data[6:3];
                    hdr_aa     <= in_data[2];
                    hdr_rd     <= in_data[0];
                end
                // ra | z | rcode, only rcode kept
                3: hdr_rcode <= in_data[3:0];
                4, 5: hdr_qdcount <= {hdr_qdcount[LO-1:0], in_data};
                6, 7: hdr_ancount <= {hdr_ancount[LO-1:0], in_data};
                // nscount and arcount are skipped
                default: ;
            endcase
        end
    end

endmodule

/* dns_field_capture.sv */
// *************************************************************************
// DNS question and answer field capture
// qtype/qclass, answer type/class/ttl, IPv4 address,
// A record check on the answer fixed fields
// *************************************************************************

`timescale 1ns/100ps

module dns_field_capture (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dns_pkg::BYTE_W-1:0] in_data,
    input  logic                       in_valid,
    input  logic [dns_pkg::SEC_W-1:0]  sec,
    input  logic [dns_pkg::OFF_W-1:0]  off,
    output logic [dns_pkg::U16_W-1:0]  qry_type,
    output logic [dns_pkg::U16_W-1:0]  qry_class,
    output logic [dns_pkg::U16_W-1:0]  ans_type,
    output logic [dns_pkg::U16_W-1:0]  ans_class,
    output logic [dns_pkg::TTL_W-1:0]  ans_ttl,
    output logic [dns_pkg::ADDR_W-1:0] ans_addr,
    output logic                       ans_ok
);

    localparam int U16_LO  = dns_pkg::U16_W - dns_pkg::BYTE_W;
    localparam int TTL_LO  = dns_pkg::TTL_W - dns_pkg::BYTE_W;
    localparam int ADDR_LO = dns_pkg::ADDR_W - dns_pkg::BYTE_W;

    // high byte of rdlength, low byte is judged on the fly
    logic [dns_pkg::BYTE_W-1:0] rdlen_hi;

    // payload shift registers
    always_ff @(posedge clk) begin
        if (in_valid) begin
            case (sec)
                dns_pkg::SEC_QFIX: begin
                    case (int'(off))
                        0, 1: qry_type  <= {qry_type[U16_LO-1:0], in_data};
                        2, 3: qry_class <= {qry_class[U16_LO-1:0], in_data};
                        default: ;
                    endcase
                end
                dns_pkg::SEC_AFIX: begin
                    case (int'(off))
                        0, 1: ans_type  <= {ans_type[U16_LO-1:0], in_data};
                        2, 3: ans_class <= {ans_class[U16_LO-1:0], in_data};
                        4, 5, 6, 7: ans_ttl <= {ans_ttl[TTL_LO-1:0], in_data};
                        8: rdlen_hi <= in_data;
                        default: ;
                    endcase
                end
                dns_pkg::SEC_RDATA: begin
                    // address only taken for a matching A record
                    if (ans_ok) begin
                        ans_addr <= {ans_addr[ADDR_LO-1:0], in_data};
                    end
                end
                default: ;
            endcase
        end
    end

    // answer check, valid the cycle after the last fixed byte
    always_ff @(posedge clk) begin
        if (rst) begin
            ans_ok <= 1'b0;
        end else if (in_valid) begin
            if (sec == dns_pkg::SEC_HDR) begin
                // fresh frame
                ans_ok <= 1'b0;
            end else if (sec == dns_pkg::SEC_AFIX &&
                         int'(off) == dns_pkg::AFIX_BYTES - 1) begin
                ans_ok <= (ans_type == dns_pkg::TYPE_A) &&
                          (ans_class == dns_pkg::CLASS_IN) &&
                          ({rdlen_hi, in_data} == dns_pkg::A_RDLEN);
            end
        end
    end

    // an address byte is only taken behind an IN class A answer of this frame
    a_addr_gate: assert property (@(posedge clk) disable iff (rst)
        (in_valid && sec == dns_pkg::SEC_RDATA && ans_ok)
            |-> (ans_type == dns_pkg::TYPE_A) && (ans_class == dns_pkg::CLASS_IN));

endmodule

/* dns_rx_top.sv */
// *************************************************************************
// DNS response analyzer top level
// parse controller, name walker, header and field capture
// *************************************************************************

`timescale 1ns/100ps

module dns_rx_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dns_pkg::BYTE_W-1:0] in_data,
    input  logic                       in_valid,
    input  logic                       in_last,
    output logic                       dns_valid,
    output logic                       dns_error,
    output logic [dns_pkg::U16_W-1:0]  hdr_id,
    output logic [dns_pkg::U16_W-1:0]  hdr_qdcount,
    output logic [dns_pkg::U16_W-1:0]  hdr_ancount,
    output logic                       hdr_qr,
    output logic                       hdr_aa,
    output logic                       hdr_rd,
    output logic [3:0]                 hdr_opcode,
    output logic [3:0]                 hdr_rcode,
    output logic [dns_pkg::U16_W-1:0]  qry_type,
    output logic [dns_pkg::U16_W-1:0]  qry_class,
    output logic [dns_pkg::U16_W-1:0]  ans_type,
    output logic [dns_pkg::U16_W-1:0]  ans_class,
    output logic [dns_pkg::TTL_W-1:0]  ans_ttl,
    output logic [dns_pkg::ADDR_W-1:0] ans_addr
);

    // section and offset of the byte on in_data
    logic [dns_pkg::SEC_W-1:0] sec;
    logic [dns_pkg::OFF_W-1:0] off;
    logic                      name_done;
    logic                      ans_ok;

    dns_parse_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .name_done (name_done),
        .ans_ok    (ans_ok),
        .sec       (sec),
        .off       (off),
        .dns_valid (dns_valid),
        .dns_error (dns_error)
    );

    dns_name_walker u_walker (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .sec       (sec),
        .name_done (name_done)
    );

    dns_hdr_capture u_hdr (
        .clk         (clk),
        .rst         (rst),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .sec         (sec),
        .off         (off),
        .hdr_id      (hdr_id),
        .hdr_qdcount (hdr_qdcount),
        .hdr_ancount (hdr_ancount),
        .hdr_qr      (hdr_qr),
        .hdr_aa      (hdr_aa),
        .hdr_rd      (hdr_rd),
        .hdr_opcode  (hdr_opcode),
        .hdr_rcode   (hdr_rcode)
    );

    dns_field_capture u_fields (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .sec       (sec),
        .off       (off),
        .qry_type  (qry_type),
        .qry_class (qry_class),
        .ans_type  (ans_type),
        .ans_class (ans_class),
        .ans_ttl   (ans_ttl),
        .ans_addr  (ans_addr),
        .ans_ok    (ans_ok)
    );

endmodule

/* tb_dns_rx.sv */
// ***************************************************************************
// testbench for the DNS response analyzer
// vector file reader, byte driver with LFSR gaps,
// field compare tasks, strobe counter and watchdog
// ***************************************************************************

`timescale 1ns/100ps

module tb_dns_rx;

    localparam int CLK_HALF   = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int MAX_FRAMES = 32;
    localparam int MAX_BYTES  = 2048;

    logic                       clk;
    logic                       rst;
    logic [dns_pkg::BYTE_W-1:0] in_data;
    logic                       in_valid;
    logic                       in_last;
    logic                       dns_valid;
    logic                       dns_error;
    logic [dns_pkg::U16_W-1:0]  hdr_id;
    logic [dns_pkg::U16_W-1:0]  hdr_qdcount;
    logic [dns_pkg::U16_W-1:0]  hdr_ancount;
    logic                       hdr_qr;
    logic                       hdr_aa;
    logic                       hdr_rd;
    logic [3:0]                 hdr_opcode;
    logic [3:0]                 hdr_rcode;
    logic [dns_pkg::U16_W-1:0]  qry_type;
    logic [dns_pkg::U16_W-1:0]  qry_class;
    logic [dns_pkg::U16_W-1:0]  ans_type;
    logic [dns_pkg::U16_W-1:0]  ans_class;
    logic [dns_pkg::TTL_W-1:0]  ans_ttl;
    logic [dns_pkg::ADDR_W-1:0] ans_addr;

    // expected results, one entry per frame
    logic [7:0]                 exp_verdict [0:MAX_FRAMES-1];
    logic [dns_pkg::U16_W-1:0]  exp_id      [0:MAX_FRAMES-1];
    logic                       exp_qr      [0:MAX_FRAMES-1];
    logic [3:0]                 exp_opcode  [0:MAX_FRAMES-1];
    logic                       exp_aa      [0:MAX_FRAMES-1];
    logic                       exp_rd      [0:MAX_FRAMES-1];
    logic [3:0]                 exp_rcode   [0:MAX_FRAMES-1];
    logic [dns_pkg::U16_W-1:0]  exp_qd      [0:MAX_FRAMES-1];
    logic [dns_pkg::U16_W-1:0]  exp_an      [0:MAX_FRAMES-1];
    logic [dns_pkg::U16_W-1:0]  exp_qtype   [0:MAX_FRAMES-1];
    logic [dns_pkg::U16_W-1:0]  exp_qclass  [0:MAX_FRAMES-1];
    logic [dns_pkg::U16_W-1:0]  exp_atype   [0:MAX_FRAMES-1];
    logic [dns_pkg::U16_W-1:0]  exp_aclass  [0:MAX_FRAMES-1];
    logic [dns_pkg::TTL_W-1:0]  exp_ttl     [0:MAX_FRAMES-1];
    logic [dns_pkg::ADDR_W-1:0] exp_addr    [0:MAX_FRAMES-1];
    logic [7:0]                 exp_mask    [0:MAX_FRAMES-1];
    int                         n_bytes     [0:MAX_FRAMES-1];
    int                         first_byte  [0:MAX_FRAMES-1];
    logic [dns_pkg::BYTE_W-1:0] frame_bytes [0:MAX_BYTES-1];

    int          n_frames;
    int          n_total;
    int          limit_cycles = 0;
    int          strobe_cnt   = 0;
    int          f;
    logic [31:0] lfsr;

    dns_rx_top DUT (
        .clk         (clk),
        .rst         (rst),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_last     (in_last),
        .dns_valid   (dns_valid),
        .dns_error   (dns_error),
        .hdr_id      (hdr_id),
        .hdr_qdcount (hdr_qdcount),
        .hdr_ancount (hdr_ancount),
        .hdr_qr      (hdr_qr),
        .hdr_aa      (hdr_aa),
        .hdr_rd      (hdr_rd),
        .hdr_opcode  (hdr_opcode),
        .hdr_rcode   (hdr_rcode),
        .qry_type    (qry_type),
        .qry_class   (qry_class),
        .ans_type    (ans_type),
        .ans_class   (ans_class),
        .ans_ttl     (ans_ttl),
        .ans_addr    (ans_addr)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // verdict strobes seen, sampled mid cycle
    always @(negedge clk) begin
        if (dns_valid || dns_error) begin
            strobe_cnt = strobe_cnt + 1;
        end
    end

    task automatic report_fail();
        $display("Errors found");
        $fatal(1);
    endtask

    // budget known once the vectors are loaded
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
        report_fail();
    end

    task automatic check_u16(input string name, input logic [dns_pkg::U16_W-1:0] exp,
                             input logic [dns_pkg::U16_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_u32(input string name, input logic [dns_pkg::TTL_W-1:0] exp,
                             input logic [dns_pkg::TTL_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_u4(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_verdict(input logic exp_ok, input logic act_valid,
                                 input logic act_error);
        if (act_valid !== 1'b1 && act_error !== 1'b1) begin
            $display("no verdict strobe in the cycle after the last byte at %0t", $time);
            report_fail();
        end else if (act_valid === 1'b1 && act_error === 1'b1) begin
            $display("dns_valid and dns_error high together at %0t", $time);
            report_fail();
        end else if (act_valid !== exp_ok) begin
            $display("[ERROR] %0t dns_valid expected %b got %b", $time, exp_ok, act_valid);
            report_fail();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // 0 to 3 idle cycles, two LFSR bits
    task automatic pick_gap(output int gap);
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            gap  = gap * 2 + lfsr[0];
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic send_byte(input logic [dns_pkg::BYTE_W-1:0] data, input logic last);
        int gap;
        in_data  = data;
        in_valid = 1'b1;
        in_last  = last;
        next_cycle();
        in_valid = 1'b0;
        in_last  = 1'b0;
        // no gap after the final byte, verdict is due now
        if (!last) begin
            pick_gap(gap);
            repeat (gap) next_cycle();
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               code;
        int               k;
        logic [63:0]      tok;
        logic [8*256-1:0] line;
        logic [31:0]      b;
        fd = $fopen("dns_rx_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open dns_rx_vectors.txt");
            report_fail();
        end
        n_frames = 0;
        n_total  = 0;
        while ($fscanf(fd, " %s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(line, fd);
            end else begin
                if (tok != "V" && tok != "E" && tok != "R") begin
                    $display("unknown verdict letter in frame %0d of the vector file", n_frames);
                    report_fail();
                end
                exp_verdict[n_frames] = tok[7:0];
                code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                               exp_id[n_frames], exp_qr[n_frames], exp_opcode[n_frames],
                               exp_aa[n_frames], exp_rd[n_frames], exp_rcode[n_frames],
                               exp_qd[n_frames], exp_an[n_frames], exp_qtype[n_frames],
                               exp_qclass[n_frames], exp_atype[n_frames],
                               exp_aclass[n_frames], exp_ttl[n_frames],
                               exp_addr[n_frames], exp_mask[n_frames], n_bytes[n_frames]);
                if (code != 16) begin
                    $display("frame %0d of the vector file has missing columns", n_frames);
                    report_fail();
                end
                first_byte[n_frames] = n_total;
                for (k = 0; k < n_bytes[n_frames]; k++) begin
                    code = $fscanf(fd, " %h", b);
                    if (code != 1) begin
                        $display("frame %0d of the vector file is short of bytes", n_frames);
                        report_fail();
                    end
                    frame_bytes[n_total] = b[7:0];
                    n_total = n_total + 1;
                end
                n_frames = n_frames + 1;
            end
        end
        $fclose(fd);
    endtask

    // mask selects which groups the frame defines
    task automatic check_fields(input int idx);
        if (exp_mask[idx][0]) begin
            check_u16("hdr_id", exp_id[idx], hdr_id);
            check_bit("hdr_qr", exp_qr[idx], hdr_qr);
            check_u4("hdr_opcode", exp_opcode[idx], hdr_opcode);
            check_bit("hdr_aa", exp_aa[idx], hdr_aa);
            check_bit("hdr_rd", exp_rd[idx], hdr_rd);
            check_u4("hdr_rcode", exp_rcode[idx], hdr_rcode);
            check_u16("hdr_qdcount", exp_qd[idx], hdr_qdcount);
            check_u16("hdr_ancount", exp_an[idx], hdr_ancount);
        end
        if (exp_mask[idx][1]) begin
            check_u16("qry_type", exp_qtype[idx], qry_type);
            check_u16("qry_class", exp_qclass[idx], qry_class);
        end
        if (exp_mask[idx][2]) begin
            check_u16("ans_type", exp_atype[idx], ans_type);
            check_u16("ans_class", exp_aclass[idx], ans_class);
        end
        if (exp_mask[idx][3]) begin
            check_u32("ans_ttl", exp_ttl[idx], ans_ttl);
        end
        if (exp_mask[idx][4]) begin
            check_u32("ans_addr", exp_addr[idx], ans_addr);
        end
    endtask

    task automatic run_frame(input int idx);
        int  i;
        logic abort;
        abort      = (exp_verdict[idx] == "R");
        strobe_cnt = 0;
        for (i = 0; i < n_bytes[idx]; i++) begin
            send_byte(frame_bytes[first_byte[idx] + i], !abort && (i == n_bytes[idx] - 1));
        end
        if (abort) begin
            // rst pulse drops the partial frame
            rst = 1'b1;
            repeat (2) next_cycle();
            rst = 1'b0;
            repeat (2) next_cycle();
            if (strobe_cnt != 0) begin
                $display("frame %0d gave a verdict strobe although it was cut by rst", idx);
                report_fail();
            end
        end else begin
            check_verdict(exp_verdict[idx] == "V", dns_valid, dns_error);
            check_fields(idx);
            next_cycle();
            if (dns_valid !== 1'b0 || dns_error !== 1'b0) begin
                $display("verdict strobe of frame %0d lasted more than one cycle", idx);
                report_fail();
            end
            next_cycle();
            if (strobe_cnt != 1) begin
                $display("frame %0d gave %0d verdict strobes instead of one", idx, strobe_cnt);
                report_fail();
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        in_data  = '0;
        in_valid = 1'b0;
        in_last  = 1'b0;
        lfsr     = 32'hd318;
        load_vectors();
        // worst case gap is 3 idle cycles per byte
        limit_cycles = n_total * 4 + n_frames * 100;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_bit("dns_valid", 1'b0, dns_valid);
        check_bit("dns_error", 1'b0, dns_error);
        for (f = 0; f < n_frames; f++) begin
            run_frame(f);
        end
        if (n_frames == 0) begin
            $display("vector file holds no frames");
            report_fail();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* dns_rx_vectors.txt */
# verdict(V/E/R) id qr opcode aa rd rcode qdcount ancount qtype qclass atype aclass ttl addr
# mask(1 hdr 2 question 4 ans type/class 8 ttl 10 addr) nbytes(dec) then the frame bytes in hex
# A record, compressed answer name
V 1a2b 1 0 0 1 0 0001 0001 0001 0001 0001 0001 00000e10 0a010203 1f 39 1a 2b 81 80 00 01 00 01 00 00 00 00 02 61 62 02 63 64 00 00 01 00 01 c0 0c 00 01 00 01 00 00 0e 10 00 04 0a 01 02 03
# same response, answer name as full labels
V 1a2c 1 0 0 1 0 0001 0001 0001 0001 0001 0001 00000e10 0a010203 1f 44 1a 2c 81 80 00 01 00 01 00 00 00 00 02 61 62 02 63 64 00 00 01 00 01 02 61 62 02 63 64 00 00 01 00 01 00 00 0e 10 00 04 0a 01 02 03
# cut off inside the answer fixed fields
E 2001 1 0 0 1 0 0001 0001 0001 0001 0001 0001 00000000 00000000 07 31 20 01 81 80 00 01 00 01 00 00 00 00 02 61 62 02 63 64 00 00 01 00 01 c0 0c 00 01 00 01 00 00
# cut off inside the address
E 2002 1 0 0 1 0 0001 0001 0001 0001 0001 0001 0000012c 00000000 0f 37 20 02 81 80 00 01 00 01 00 00 00 00 02 61 62 02 63 64 00 00 01 00 01 c0 0c 00 01 00 01 00 00 01 2c 00 04 0a 01
# CNAME answer with six data bytes
E 3003 1 0 0 1 0 0001 0001 0001 0001 0005 0001 00000258 00000000 0f 41 30 03 81 80 00 01 00 01 00 00 00 00 02 61 62 02 63 64 00 00 01 00 01 c0 0c 00 05 00 01 00 00 02 58 00 06 03 77 77 77 c0 0c
# aa set, trailing second answer bytes go to the tail
V 4004 1 0 1 1 0 0001 0002 0001 0001 0001 0001 0000003c 08080808 1f 39 40 04 85 80 00 01 00 02 00 00 00 00 01 78 00 00 01 00 01 c0 0c 00 01 00 01 00 00 00 3c 00 04 08 08 08 08 c0 0c 00 05
# opcode 2, tc set, rcode 3, no answer section
E 4005 1 2 1 1 3 0001 0000 001c 0001 0000 0000 00000000 00000000 03 21 40 05 97 83 00 01 00 00 00 00 00 00 03 61 62 63 00 00 1c 00 01
# plain query, qr clear
E 5005 0 0 0 1 0 0001 0000 0001 0001 0000 0000 00000000 00000000 03 19 50 05 01 00 00 01 00 00 00 00 00 00 01 78 00 00 01 00 01
# opcode 15 and rcode 15 with a full A answer
V 6006 1 f 1 0 f 0001 0001 0001 0001 0001 0001 ffffffff c0a80001 1f 35 60 06 fc 8f 00 01 00 01 00 00 00 00 01 79 00 00 01 00 01 c0 0c 00 01 00 01 ff ff ff ff 00 04 c0 a8 00 01
# partial frame stopped inside a pointer, then rst
R 0000 0 0 0 0 0 0000 0000 0000 0000 0000 0000 00000000 00000000 00 24 1a 2b 81 80 00 01 00 01 00 00 00 00 02 61 62 02 63 64 00 00 01 00 01 c0
# full frame after the rst, label then pointer in the answer name
V 7007 1 0 0 1 0 0001 0001 0001 0001 0001 0001 00001234 7f000001 1f 40 70 07 81 80 00 01 00 01 00 00 00 00 02 61 62 00 00 01 00 01 03 77 77 77 c0 0c 00 01 00 01 00 00 12 34 00 04 7f 00 00 01

/* flist.f */
dns_pkg.sv
dns_parse_ctrl.sv
dns_name_walker.sv
dns_hdr_capture.sv
dns_field_capture.sv
dns_rx_top.sv
tb_dns_rx.sv
